// File: common/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register file
`define RV_NREGS 32
`define RV_REG_AW 5

// First fetch address
`define RV_RESET_PC 32'h0000_0000

`endif

// File: common/rv_pkg.sv
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS2    // Second operand straight through
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_type_e;

    // WD_ALU is zero so an all-zero bubble writes nothing odd
    typedef enum logic [1:0] {
        WD_ALU,
        WD_PC4,
        WD_MEM,
        WD_IMM
    } wd_sel_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     imm;
        word_t     rd0;
        word_t     rd1;
        reg_addr_t ra0;
        reg_addr_t ra1;
        logic      re0;
        logic      re1;
        reg_addr_t wa;
        logic      we;
        wd_sel_e   wd_sel;
        alu_op_e   alu_op;
        br_type_e  br_type;
        logic      src1_pc;
        logic      src2_imm;
        logic      jal;
        logic      jalr;
        logic      mem_we;
        logic      is_load;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_ans;
        word_t     store_data;
        word_t     pc_add4;
        word_t     imm;
        reg_addr_t wa;
        logic      we;
        wd_sel_e   wd_sel;
        logic      mem_we;
    } ex_mem_t;

    typedef struct packed {
        word_t     alu_ans;
        word_t     load_data;
        word_t     pc_add4;
        word_t     imm;
        reg_addr_t wa;
        logic      we;
        wd_sel_e   wd_sel;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/rv_stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module rv_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            q <= '0;    // Bubble, all writes off
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              we,
    input  rv_pkg::reg_addr_t ra0,
    input  rv_pkg::reg_addr_t ra1,
    input  rv_pkg::reg_addr_t wa,
    input  rv_pkg::reg_addr_t ra_dbg,
    input  rv_pkg::word_t     wd,
    output rv_pkg::word_t     rd0,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd_dbg
);
    import rv_pkg::*;

    word_t regs [1:`RV_NREGS-1];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rd0    = (ra0 == '0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1    = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd_dbg = (ra_dbg == '0) ? '0 : (we && wa == ra_dbg) ? wd : regs[ra_dbg];

endmodule

`default_nettype wire

// File: hw/rv_hazard.sv
`timescale 1ns/100ps
`default_nettype none

module rv_hazard (
    input  rv_pkg::reg_addr_t ra0_id,
    input  rv_pkg::reg_addr_t ra1_id,
    input  rv_pkg::reg_addr_t ra0_ex,
    input  rv_pkg::reg_addr_t ra1_ex,
    input  rv_pkg::reg_addr_t wa_ex,
    input  rv_pkg::reg_addr_t wa_mem,
    input  rv_pkg::reg_addr_t wa_wb,
    input  logic              re0_id,
    input  logic              re1_id,
    input  logic              re0_ex,
    input  logic              re1_ex,
    input  logic              is_load_ex,
    input  logic              we_mem,
    input  logic              we_wb,
    input  logic              redirect,
    input  rv_pkg::wd_sel_e   wd_sel_mem,
    input  rv_pkg::word_t     alu_ans_mem,
    input  rv_pkg::word_t     pc_add4_mem,
    input  rv_pkg::word_t     imm_mem,
    input  rv_pkg::word_t     wd_wb,
    output logic              fwd0_en,
    output logic              fwd1_en,
    output logic              stall_if,
    output logic              stall_id,
    output logic              flush_id,
    output logic              flush_ex,
    output rv_pkg::word_t     fwd0_data,
    output rv_pkg::word_t     fwd1_data
);
    import rv_pkg::*;

    logic  hit0_mem, hit1_mem, hit0_wb, hit1_wb;
    logic  load_use;
    word_t mem_val;

    assign hit0_mem = re0_ex && we_mem && wa_mem != '0 && wa_mem == ra0_ex;
    assign hit1_mem = re1_ex && we_mem && wa_mem != '0 && wa_mem == ra1_ex;
    assign hit0_wb  = re0_ex && we_wb && wa_wb != '0 && wa_wb == ra0_ex;
    assign hit1_wb  = re1_ex && we_wb && wa_wb != '0 && wa_wb == ra1_ex;

    // A load never sits in memory with a consumer in execute
    always_comb begin
        case (wd_sel_mem)
            WD_PC4:  mem_val = pc_add4_mem;
            WD_IMM:  mem_val = imm_mem;
            default: mem_val = alu_ans_mem;
        endcase
    end

    assign fwd0_en   = hit0_mem || hit0_wb;
    assign fwd1_en   = hit1_mem || hit1_wb;
    assign fwd0_data = hit0_mem ? mem_val : wd_wb;    // Younger result wins
    assign fwd1_data = hit1_mem ? mem_val : wd_wb;

    assign load_use = is_load_ex && wa_ex != '0 &&
                      ((re0_id && ra0_id == wa_ex) || (re1_id && ra1_id == wa_ex));

    assign stall_if = load_use && !redirect;
    assign stall_id = load_use && !redirect;
    assign flush_id = redirect;
    assign flush_ex = redirect || load_use;

endmodule

`default_nettype wire

// File: hw/decode/rv_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
    input  rv_pkg::word_t    inst,
    output logic             rf_re0,
    output logic             rf_re1,
    output logic             rf_we,
    output logic             alu_src1_pc,
    output logic             alu_src2_imm,
    output logic             jal,
    output logic             jalr,
    output logic             mem_we,
    output logic             is_load,
    output rv_pkg::wd_sel_e  rf_wd_sel,
    output rv_pkg::alu_op_e  alu_op,
    output rv_pkg::br_type_e br_type,
    output rv_pkg::word_t    imm
);
    import rv_pkg::*;

    logic [2:0] funct3;
    word_t      i_imm, s_imm, b_imm, u_imm, j_imm;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct3 = inst[14:12];
    assign i_imm  = {{20{inst[31]}}, inst[31:20]};
    assign s_imm  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm  = {inst[31:12], 12'b0};
    assign j_imm  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        rf_re0       = 1'b0;
        rf_re1       = 1'b0;
        rf_we        = 1'b0;
        alu_src1_pc  = 1'b0;
        alu_src2_imm = 1'b0;
        jal          = 1'b0;
        jalr         = 1'b0;
        mem_we       = 1'b0;
        is_load      = 1'b0;
        rf_wd_sel    = WD_ALU;
        alu_op       = ALU_ADD;
        br_type      = BR_NONE;
        imm          = '0;
        case (inst[6:0])
            OP_REG: begin
                {rf_re0, rf_re1, rf_we} = 3'b111;
                alu_op = alu_decode(funct3, inst[30]);
            end
            OP_IMM: begin
                {rf_re0, rf_we, alu_src2_imm} = 3'b111;
                imm    = i_imm;
                alu_op = alu_decode(funct3, funct3 == 3'b101 && inst[30]);   // Only srai
            end
            OP_LOAD: begin
                {rf_re0, rf_we, alu_src2_imm, is_load} = 4'b1111;
                imm       = i_imm;
                rf_wd_sel = WD_MEM;
            end
            OP_STORE: begin
                {rf_re0, rf_re1, alu_src2_imm, mem_we} = 4'b1111;
                imm = s_imm;
            end
            OP_BRANCH: begin
                {rf_re0, rf_re1, alu_src1_pc, alu_src2_imm} = 4'b1111;
                imm = b_imm;    // Target from pc + imm
                case (funct3)
                    3'b000:  br_type = BR_EQ;
                    3'b001:  br_type = BR_NE;
                    3'b100:  br_type = BR_LT;
                    3'b101:  br_type = BR_GE;
                    3'b110:  br_type = BR_LTU;
                    3'b111:  br_type = BR_GEU;
                    default: br_type = BR_NONE;
                endcase
            end
            OP_JAL: begin
                {rf_we, alu_src1_pc, alu_src2_imm, jal} = 4'b1111;
                imm       = j_imm;
                rf_wd_sel = WD_PC4;
            end
            OP_JALR: begin
                {rf_re0, rf_we, alu_src2_imm, jalr} = 4'b1111;
                imm       = i_imm;
                rf_wd_sel = WD_PC4;
            end
            OP_LUI: begin
                {rf_we, alu_src2_imm} = 2'b11;
                imm       = u_imm;
                alu_op    = ALU_PASS2;
                rf_wd_sel = WD_IMM;
            end
            OP_AUIPC: begin
                {rf_we, alu_src1_pc, alu_src2_imm} = 3'b111;
                imm = u_imm;
            end
            default: ;    // Unknown opcode stays a bubble
        endcase
    end

endmodule

`default_nettype wire

// File: hw/execute/rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::word_t    rd0_raw,
    input  rv_pkg::word_t    rd1_raw,
    input  rv_pkg::word_t    fwd0_data,
    input  rv_pkg::word_t    fwd1_data,
    input  logic             fwd0_en,
    input  logic             fwd1_en,
    input  logic             alu_src1_pc,
    input  logic             alu_src2_imm,
    input  logic             jal,
    input  logic             jalr,
    input  rv_pkg::alu_op_e  alu_op,
    input  rv_pkg::br_type_e br_type,
    output rv_pkg::word_t    alu_ans,
    output rv_pkg::word_t    store_data,
    output logic             redirect,
    output rv_pkg::word_t    redirect_pc
);
    import rv_pkg::*;

    word_t rd0, rd1, src1, src2;
    logic  br_taken;

    assign rd0  = fwd0_en ? fwd0_data : rd0_raw;
    assign rd1  = fwd1_en ? fwd1_data : rd1_raw;
    assign src1 = alu_src1_pc ? pc : rd0;
    assign src2 = alu_src2_imm ? imm : rd1;

    always_comb begin
        case (alu_op)
            ALU_ADD:   alu_ans = src1 + src2;
            ALU_SUB:   alu_ans = src1 - src2;
            ALU_AND:   alu_ans = src1 & src2;
            ALU_OR:    alu_ans = src1 | src2;
            ALU_XOR:   alu_ans = src1 ^ src2;
            ALU_SLT:   alu_ans = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU:  alu_ans = word_t'(src1 < src2);
            ALU_SLL:   alu_ans = src1 << src2[4:0];
            ALU_SRL:   alu_ans = src1 >> src2[4:0];
            ALU_SRA:   alu_ans = word_t'($signed(src1) >>> src2[4:0]);
            ALU_PASS2: alu_ans = src2;
            default:   alu_ans = '0;
        endcase
    end

    // Compare the forwarded registers, not the ALU operands
    always_comb begin
        case (br_type)
            BR_EQ:   br_taken = rd0 == rd1;
            BR_NE:   br_taken = rd0 != rd1;
            BR_LT:   br_taken = $signed(rd0) < $signed(rd1);
            BR_GE:   br_taken = $signed(rd0) >= $signed(rd1);
            BR_LTU:  br_taken = rd0 < rd1;
            BR_GEU:  br_taken = rd0 >= rd1;
            default: br_taken = 1'b0;
        endcase
    end

    assign store_data  = rd1;
    assign redirect    = jal || jalr || br_taken;
    assign redirect_pc = jalr ? {alu_ans[31:1], 1'b0} : alu_ans;

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core (
    input  logic              clk,
    input  logic              rst_n,
    output rv_pkg::word_t     im_addr,
    input  rv_pkg::word_t     im_dout,
    output rv_pkg::word_t     mem_addr,
    output logic              mem_we,
    output rv_pkg::word_t     mem_din,
    input  rv_pkg::word_t     mem_dout,
    output rv_pkg::word_t     current_pc,
    output rv_pkg::word_t     next_pc,
    input  rv_pkg::reg_addr_t cpu_check_addr,
    output rv_pkg::word_t     cpu_check_data
);
    import rv_pkg::*;

    word_t   pc, pc_add4, redirect_pc, wd_wb;
    word_t   fwd0_data, fwd1_data;
    logic    redirect, fwd0_en, fwd1_en;
    logic    stall_if, stall_id, flush_id, flush_ex;
    if_id_t  if_id_d, if_id_q;
    id_ex_t  id_ex_d, id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    // Fetch, predicted not-taken
    assign pc_add4 = pc + `RV_XLEN'd4;
    assign next_pc = redirect ? redirect_pc : pc_add4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (!stall_if) begin
            pc <= next_pc;
        end
    end

    assign im_addr    = pc;
    assign current_pc = pc;
    assign if_id_d    = '{pc: pc, inst: im_dout};

    rv_stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall_id),
        .flush (flush_id),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    // Decode
    assign id_ex_d.pc  = if_id_q.pc;
    assign id_ex_d.ra0 = if_id_q.inst[19:15];
    assign id_ex_d.ra1 = if_id_q.inst[24:20];
    assign id_ex_d.wa  = if_id_q.inst[11:7];

    rv_decoder u_decoder (
        .inst         (if_id_q.inst),
        .rf_re0       (id_ex_d.re0),
        .rf_re1       (id_ex_d.re1),
        .rf_we        (id_ex_d.we),
        .alu_src1_pc  (id_ex_d.src1_pc),
        .alu_src2_imm (id_ex_d.src2_imm),
        .jal          (id_ex_d.jal),
        .jalr         (id_ex_d.jalr),
        .mem_we       (id_ex_d.mem_we),
        .is_load      (id_ex_d.is_load),
        .rf_wd_sel    (id_ex_d.wd_sel),
        .alu_op       (id_ex_d.alu_op),
        .br_type      (id_ex_d.br_type),
        .imm          (id_ex_d.imm)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .we     (mem_wb_q.we),
        .ra0    (id_ex_d.ra0),
        .ra1    (id_ex_d.ra1),
        .wa     (mem_wb_q.wa),
        .ra_dbg (cpu_check_addr),
        .wd     (wd_wb),
        .rd0    (id_ex_d.rd0),
        .rd1    (id_ex_d.rd1),
        .rd_dbg (cpu_check_data)
    );

    rv_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (1'b0),
        .flush (flush_ex),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // Execute
    rv_execute u_execute (
        .pc           (id_ex_q.pc),
        .imm          (id_ex_q.imm),
        .rd0_raw      (id_ex_q.rd0),
        .rd1_raw      (id_ex_q.rd1),
        .fwd0_data    (fwd0_data),
        .fwd1_data    (fwd1_data),
        .fwd0_en      (fwd0_en),
        .fwd1_en      (fwd1_en),
        .alu_src1_pc  (id_ex_q.src1_pc),
        .alu_src2_imm (id_ex_q.src2_imm),
        .jal          (id_ex_q.jal),
        .jalr         (id_ex_q.jalr),
        .alu_op       (id_ex_q.alu_op),
        .br_type      (id_ex_q.br_type),
        .alu_ans      (ex_mem_d.alu_ans),
        .store_data   (ex_mem_d.store_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    assign ex_mem_d.pc_add4 = id_ex_q.pc + `RV_XLEN'd4;    // Link value
    assign ex_mem_d.imm     = id_ex_q.imm;
    assign ex_mem_d.wa      = id_ex_q.wa;
    assign ex_mem_d.we      = id_ex_q.we;
    assign ex_mem_d.wd_sel  = id_ex_q.wd_sel;
    assign ex_mem_d.mem_we  = id_ex_q.mem_we;

    rv_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (1'b0),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // Memory
    assign mem_addr = ex_mem_q.alu_ans;
    assign mem_din  = ex_mem_q.store_data;
    assign mem_we   = ex_mem_q.mem_we;
    assign mem_wb_d = '{alu_ans:   ex_mem_q.alu_ans,
                        load_data: mem_dout,
                        pc_add4:   ex_mem_q.pc_add4,
                        imm:       ex_mem_q.imm,
                        wa:        ex_mem_q.wa,
                        we:        ex_mem_q.we,
                        wd_sel:    ex_mem_q.wd_sel};

    rv_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (1'b0),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    // Writeback
    always_comb begin
        case (mem_wb_q.wd_sel)
            WD_PC4:  wd_wb = mem_wb_q.pc_add4;
            WD_MEM:  wd_wb = mem_wb_q.load_data;
            WD_IMM:  wd_wb = mem_wb_q.imm;
            default: wd_wb = mem_wb_q.alu_ans;
        endcase
    end

    rv_hazard u_hazard (
        .ra0_id      (id_ex_d.ra0),
        .ra1_id      (id_ex_d.ra1),
        .ra0_ex      (id_ex_q.ra0),
        .ra1_ex      (id_ex_q.ra1),
        .wa_ex       (id_ex_q.wa),
        .wa_mem      (ex_mem_q.wa),
        .wa_wb       (mem_wb_q.wa),
        .re0_id      (id_ex_d.re0),
        .re1_id      (id_ex_d.re1),
        .re0_ex      (id_ex_q.re0),
        .re1_ex      (id_ex_q.re1),
        .is_load_ex  (id_ex_q.is_load),
        .we_mem      (ex_mem_q.we),
        .we_wb       (mem_wb_q.we),
        .redirect    (redirect),
        .wd_sel_mem  (ex_mem_q.wd_sel),
        .alu_ans_mem (ex_mem_q.alu_ans),
        .pc_add4_mem (ex_mem_q.pc_add4),
        .imm_mem     (ex_mem_q.imm),
        .wd_wb       (wd_wb),
        .fwd0_en     (fwd0_en),
        .fwd1_en     (fwd1_en),
        .stall_if    (stall_if),
        .stall_id    (stall_id),
        .flush_id    (flush_id),
        .flush_ex    (flush_ex),
        .fwd0_data   (fwd0_data),
        .fwd1_data   (fwd1_data)
    );

endmodule

`default_nettype wire

// File: sim/rv_tb_mem.sv
`timescale 1ns/100ps
`default_nettype none

module rv_tb_mem (
    input  logic          clk,
    input  rv_pkg::word_t rand_a,
    input  rv_pkg::word_t rand_b,
    input  rv_pkg::word_t im_addr,
    output rv_pkg::word_t im_dout,
    input  rv_pkg::word_t mem_addr,
    input  logic          mem_we,
    input  rv_pkg::word_t mem_din,
    output rv_pkg::word_t mem_dout
);
    import rv_pkg::*;

    // Branch blocks: one taken and one not-taken per kind, x22 = -3, x23 = 5
    localparam int BR_F3 [12]  = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    localparam int BR_RS1 [12] = '{22, 22, 22, 22, 22, 23, 23, 22, 23, 22, 22, 23};
    localparam int BR_RS2 [12] = '{22, 23, 23, 22, 23, 22, 22, 23, 22, 23, 23, 22};

    word_t rom [0:127];
    word_t ram [0:255];

    function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t enc_i(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'd2, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_u(int imm, int rd, int op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    always_comb begin
        logic [6:0] idx;
        for (int i = 0; i < 128; i++) begin
            rom[i] = 32'h0000_0013;    // nop
        end
        rom[0]  = enc_u(int'(rand_a[31:12]), 1, 'h37);
        rom[1]  = enc_i(int'(rand_a[11:0]), 1, 0, 1, 'h13);
        rom[2]  = enc_u(int'(rand_b[31:12]), 2, 'h37);
        rom[3]  = enc_i(int'(rand_b[11:0]), 2, 0, 2, 'h13);
        rom[4]  = enc_r(0, 2, 1, 0, 3);           // add
        rom[5]  = enc_r('h20, 1, 3, 0, 4);        // sub
        rom[6]  = enc_r(0, 3, 4, 4, 5);           // xor
        rom[7]  = enc_r(0, 2, 5, 6, 6);           // or
        rom[8]  = enc_r(0, 1, 6, 7, 7);           // and
        rom[9]  = enc_r(0, 2, 1, 1, 8);           // sll
        rom[10] = enc_r(0, 2, 1, 5, 9);           // srl
        rom[11] = enc_r('h20, 2, 1, 5, 10);       // sra
        rom[12] = enc_r(0, 2, 1, 2, 11);          // slt
        rom[13] = enc_r(0, 2, 1, 3, 12);          // sltu
        rom[14] = enc_i(7, 1, 1, 13, 'h13);       // slli
        rom[15] = enc_i('h403, 1, 5, 14, 'h13);   // srai
        rom[16] = enc_i(-5, 2, 2, 15, 'h13);      // slti
        rom[17] = enc_u('h12345, 16, 'h17);       // auipc
        rom[18] = enc_i(5, 1, 0, 0, 'h13);        // write to x0
        rom[19] = enc_r(0, 1, 0, 0, 17);
        rom[20] = enc_i('h100, 0, 0, 20, 'h13);   // data base
        rom[21] = enc_s(0, 3, 20);
        rom[22] = enc_s(4, 4, 20);
        rom[23] = enc_i(0, 20, 2, 18, 'h03);
        rom[24] = enc_r(0, 1, 18, 0, 19);         // Load-use on rs1
        rom[25] = enc_s(8, 19, 20);
        rom[26] = enc_i(4, 20, 2, 21, 'h03);
        rom[27] = enc_s(12, 21, 20);              // Load-use on store data
        rom[28] = enc_i(-3, 0, 0, 22, 'h13);
        rom[29] = enc_i(5, 0, 0, 23, 'h13);
        for (logic [3:0] b = 0; b < 12; b++) begin
            idx = 7'(30 + 3 * int'(b));
            rom[idx]        = enc_b(12, BR_RS2[b], BR_RS1[b], BR_F3[b]);
            rom[idx + 7'd1] = enc_i(1, 24, 0, 24, 'h13);    // Shadow on taken
            rom[idx + 7'd2] = enc_s(16, 24, 20);
        end
        rom[66] = enc_j(12, 25);
        rom[67] = enc_i(7, 0, 0, 26, 'h13);
        rom[68] = enc_s(20, 26, 20);
        rom[69] = enc_u(0, 27, 'h17);
        rom[70] = enc_i(17, 27, 0, 28, 'h67);     // Odd target, bit 0 dropped
        rom[71] = enc_i(9, 0, 0, 29, 'h13);
        rom[72] = enc_s(24, 29, 20);
        rom[73] = enc_s(28, 25, 20);
        rom[74] = enc_s(32, 28, 20);
        rom[75] = enc_j(0, 0);                    // Halt loop
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            ram[i] = 32'h9e37_79b9 * 32'(i) ^ 32'h1357_2468;
        end
    end

    always @(posedge clk) begin
        if (mem_we) begin
            ram[mem_addr[9:2]] <= mem_din;
        end
    end

    assign im_dout  = rom[im_addr[8:2]];
    assign mem_dout = ram[mem_addr[9:2]];

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int    N_INSTR = 76;
    localparam int    TIMEOUT = 40 * N_INSTR;
    localparam word_t HALT    = 32'h0000_006f;

    logic      clk;
    logic      rst_n;
    reg_addr_t cpu_check_addr;
    word_t     im_addr, im_dout, mem_addr, mem_din, mem_dout;
    word_t     current_pc, next_pc, cpu_check_data;
    logic      mem_we;
    word_t     rand_a, rand_b;
    word_t     halt_pc;
    int        cycles = 0;
    int        hold;

    word_t exp_regs [0:31];
    word_t exp_st_addr [$];
    word_t exp_st_data [$];
    word_t dmem [word_t];

    rv_core u_rv_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .im_addr        (im_addr),
        .im_dout        (im_dout),
        .mem_addr       (mem_addr),
        .mem_we         (mem_we),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .current_pc     (current_pc),
        .next_pc        (next_pc),
        .cpu_check_addr (cpu_check_addr),
        .cpu_check_data (cpu_check_data)
    );

    rv_tb_mem u_tb_mem (
        .clk      (clk),
        .rand_a   (rand_a),
        .rand_b   (rand_b),
        .im_addr  (im_addr),
        .im_dout  (im_dout),
        .mem_addr (mem_addr),
        .mem_we   (mem_we),
        .mem_din  (mem_din),
        .mem_dout (mem_dout)
    );

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("** Error: %s expected %h actual %h", name, exp, act);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic word_t fill_word(input word_t addr);
        return 32'h9e37_79b9 * {24'b0, addr[9:2]} ^ 32'h1357_2468;
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t x, input word_t y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return {31'b0, $signed(x) < $signed(y)};
            3'd3:    return {31'b0, x < y};
            3'd4:    return x ^ y;
            3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    // Instruction-level model of the program in the ROM
    task automatic run_reference();
        word_t pc, next, ins, a, b, res, addr;
        word_t imm_i, imm_s, imm_b, imm_u, imm_j;
        logic  wr, taken;
        int    steps;
        steps = 0;
        pc = `RV_RESET_PC;
        for (int r = 0; r < 32; r++) begin
            exp_regs[r] = '0;
        end
        ins = u_tb_mem.rom[pc[8:2]];
        while (ins != HALT) begin
            a     = exp_regs[ins[19:15]];
            b     = exp_regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_u = {ins[31:12], 12'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next  = pc + 32'd4;
            wr    = 1'b1;
            res   = '0;
            case (ins[6:0])
                7'h37: res = imm_u;
                7'h17: res = pc + imm_u;
                7'h6f: begin
                    res  = pc + 32'd4;
                    next = pc + imm_j;
                end
                7'h67: begin
                    res  = pc + 32'd4;
                    next = (a + imm_i) & ~32'd1;
                end
                7'h03: begin
                    addr = a + imm_i;
                    res  = dmem.exists(addr) ? dmem[addr] : fill_word(addr);
                end
                7'h23: begin
                    wr   = 1'b0;
                    addr = a + imm_s;
                    dmem[addr] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                7'h63: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'd0:    taken = a == b;
                        3'd1:    taken = a != b;
                        3'd4:    taken = $signed(a) < $signed(b);
                        3'd5:    taken = $signed(a) >= $signed(b);
                        3'd6:    taken = a < b;
                        default: taken = a >= b;
                    endcase
                    if (taken) next = pc + imm_b;
                end
                7'h13: res = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
                7'h33: res = alu_ref(ins[14:12], ins[30], a, b);
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) exp_regs[ins[11:7]] = res;
            pc  = next;
            ins = u_tb_mem.rom[pc[8:2]];
            steps++;
            if (steps > 1000) abort_run("reference model never reached the halt loop");
        end
        halt_pc = pc;
    endtask

    task automatic check_registers();
        for (logic [5:0] r = 0; r < 32; r++) begin
            @(posedge clk);
            #2 cpu_check_addr = r[4:0];
            @(negedge clk);
            assert (cpu_check_data == exp_regs[r[4:0]])
                else report_mismatch($sformatf("register x%0d", r), exp_regs[r[4:0]],
                                     cpu_check_data);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) abort_run("timeout, the core did not reach the halt loop");
    end

    // Reset cycles and the first cycle after
    always @(negedge clk) begin
        if (cycles >= 1 && cycles <= 3) begin
            assert (!mem_we) else report_mismatch("reset mem_we", '0, {31'b0, mem_we});
            assert (current_pc == `RV_RESET_PC)
                else report_mismatch("reset current_pc", `RV_RESET_PC, current_pc);
        end
    end

    always @(negedge clk) begin
        if (rst_n && mem_we) begin
            assert (exp_st_addr.size() > 0) else abort_run("store found beyond the expected ones");
            assert (mem_addr == exp_st_addr[0])
                else report_mismatch("store address", exp_st_addr[0], mem_addr);
            assert (mem_din == exp_st_data[0])
                else report_mismatch("store data", exp_st_data[0], mem_din);
            void'(exp_st_addr.pop_front());
            void'(exp_st_data.pop_front());
        end
    end

    // PC takes next_pc at each edge, or holds during a load-use stall
    assert property (@(posedge clk) disable iff (!rst_n)
        rst_n |=> (current_pc == $past(next_pc) || current_pc == $past(current_pc)))
        else abort_run("current_pc neither took next_pc nor held");

    initial begin
        void'($urandom(32'ha26b));
        rand_a         = $urandom();
        rand_b         = $urandom();
        rst_n          = 1'b0;
        cpu_check_addr = '0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        run_reference();
        hold = 0;
        while (hold < 8) begin
            @(negedge clk);
            // Halt jump in execute while the second fetch behind it is in fetch
            if (current_pc == halt_pc + 32'd8) begin
                assert (next_pc == halt_pc)
                    else report_mismatch("halt loop next_pc", halt_pc, next_pc);
            end
            hold = (current_pc >= halt_pc && current_pc <= halt_pc + 32'd8) ? hold + 1 : 0;
        end
        check_registers();
        assert (exp_st_addr.size() == 0) else abort_run("expected stores never appeared");
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+common
common/rv_pkg.sv
hw/rv_stage_reg.sv
hw/rv_regfile.sv
hw/rv_hazard.sv
hw/decode/rv_decoder.sv
hw/execute/rv_execute.sv
hw/rv_core.sv
sim/rv_tb_mem.sv
sim/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
